//--- Makefile
obj_dir/Vtb_ccu: files.f $(wildcard src/*.sv tb/*.sv)
	verilator --binary --timing --assert --timescale 1ns/10ps \
		--top-module tb_ccu -Mdir obj_dir -o Vtb_ccu -f files.f

run: obj_dir/Vtb_ccu
	./obj_dir/Vtb_ccu 2>&1 | tee sim.log
	! grep -qF '*** TEST FAILED ***' sim.log

check: run
	grep -qF '*** TEST PASSED ***' sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run check clean

//--- files.f
src/ccu_cfg_pkg.sv
src/ccu_types_pkg.sv
src/vq_entry.sv
src/victim_queue.sv
src/ccu_writeback.sv
src/ccu_top.sv
tb/ccu_asserts.sv
tb/tb_ccu.sv

//--- src/ccu_cfg_pkg.sv
`default_nettype none

package ccu_cfg_pkg;

    // Byte address and cache line geometry
    localparam int CCU_ADDR_WIDTH   = 32;
    localparam int CCU_LINE_BYTES   = 32;
    localparam int CCU_OFFSET_WIDTH = $clog2(CCU_LINE_BYTES);
    localparam int CCU_LINE_WIDTH   = CCU_LINE_BYTES * 8;

    // Memory write port, one word per beat
    localparam int CCU_BEAT_WIDTH        = 64;
    localparam int CCU_BEATS             = CCU_LINE_WIDTH / CCU_BEAT_WIDTH;
    localparam int CCU_BEAT_IDX_WIDTH    = $clog2(CCU_BEATS);
    // Byte offset bits inside one beat, always zero on the bus
    localparam int CCU_BEAT_OFFSET_WIDTH = $clog2(CCU_BEAT_WIDTH / 8);

    // Victim queue sizing, depth is a power of two so pointers wrap freely
    localparam int CCU_VQ_DEPTH     = 4;
    localparam int CCU_VQ_IDX_WIDTH = $clog2(CCU_VQ_DEPTH);

endpackage

`default_nettype wire

//--- src/ccu_top.sv
`timescale 1ns/10ps
`default_nettype none

module ccu_top
    import ccu_types_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       i_arst_n,

    input  wire logic       i_alloc_en,
    input  wire vq_line_t   i_alloc_line,

    input  wire line_addr_t i_lookup_addr,
    output logic            o_lookup_hit,

    output logic            o_vq_full,
    output logic            o_vq_empty,

    input  wire logic       i_mem_ack,
    output logic            o_mem_wr_valid,
    output mem_wr_t         o_mem_wr
);

    logic     head_valid;
    vq_line_t head_line;
    logic     wb_done;

    victim_queue u_victim_queue (
        .clk           (clk),
        .i_arst_n      (i_arst_n),
        .i_alloc_en    (i_alloc_en),
        .i_alloc_line  (i_alloc_line),
        .i_lookup_addr (i_lookup_addr),
        .o_lookup_hit  (o_lookup_hit),
        .i_done        (wb_done),
        .o_head_valid  (head_valid),
        .o_head_line   (head_line),
        .o_vq_full     (o_vq_full),
        .o_vq_empty    (o_vq_empty)
    );

    ccu_writeback u_ccu_writeback (
        .clk            (clk),
        .i_arst_n       (i_arst_n),
        .i_head_valid   (head_valid),
        .i_head_line    (head_line),
        .i_mem_ack      (i_mem_ack),
        .o_mem_wr_valid (o_mem_wr_valid),
        .o_mem_wr       (o_mem_wr),
        .o_done         (wb_done)
    );

endmodule

`default_nettype wire

//--- src/ccu_types_pkg.sv
`default_nettype none

package ccu_types_pkg;

    import ccu_cfg_pkg::*;

    // Line address, the byte address without its offset bits
    typedef logic [CCU_ADDR_WIDTH-CCU_OFFSET_WIDTH-1:0] line_addr_t;

    // One victimized line as allocated, stored and drained
    typedef struct packed {
        line_addr_t                addr;
        logic [CCU_LINE_WIDTH-1:0] data;
    } vq_line_t;

    // One memory write beat
    // Address is line address, beat index, then zero byte bits
    typedef struct packed {
        logic [CCU_ADDR_WIDTH-1:0] addr;
        logic [CCU_BEAT_WIDTH-1:0] data;
    } mem_wr_t;

endpackage

`default_nettype wire

//--- src/ccu_writeback.sv
`timescale 1ns/10ps
`default_nettype none

module ccu_writeback
    import ccu_cfg_pkg::*;
    import ccu_types_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     i_arst_n,

    // Oldest victim from the queue
    input  wire logic     i_head_valid,
    input  wire vq_line_t i_head_line,

    // Memory write port, beat held until acked
    input  wire logic     i_mem_ack,
    output logic          o_mem_wr_valid,
    output mem_wr_t       o_mem_wr,

    // Frees the head entry
    output logic          o_done
);

    typedef enum logic [1:0] {
        WB_IDLE   = 2'b00,
        WB_SEND   = 2'b01,
        WB_FINISH = 2'b10
    } wb_state_t;

    wb_state_t                     state_r;
    wb_state_t                     state_next;
    vq_line_t                      line_r;
    logic [CCU_BEAT_IDX_WIDTH-1:0] beat_cnt_r;
    logic                          last_beat;

    assign last_beat = (beat_cnt_r == CCU_BEAT_IDX_WIDTH'(CCU_BEATS - 1));

    always_comb begin
        state_next = state_r;
        case (state_r)
            WB_IDLE:   state_next = i_head_valid ? WB_SEND : WB_IDLE;
            WB_SEND:   state_next = (i_mem_ack && last_beat) ? WB_FINISH : WB_SEND;
            WB_FINISH: state_next = WB_IDLE;
            default:   state_next = WB_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state_r    <= WB_IDLE;
            beat_cnt_r <= '0;
        end else begin
            state_r <= state_next;
            if (state_r == WB_IDLE) begin
                beat_cnt_r <= '0;
            end else if (state_r == WB_SEND && i_mem_ack) begin
                // Wraps back to zero after the last beat
                beat_cnt_r <= beat_cnt_r + 1'b1;
            end
        end
    end

    // Take a copy of the head so the beats stay stable under back-pressure
    always_ff @(posedge clk) begin
        if (state_r == WB_IDLE && i_head_valid) begin
            line_r <= i_head_line;
        end
    end

    // Lowest word goes out first
    assign o_mem_wr_valid = (state_r == WB_SEND);
    assign o_mem_wr.addr  = {line_r.addr, beat_cnt_r, {CCU_BEAT_OFFSET_WIDTH{1'b0}}};
    assign o_mem_wr.data  = line_r.data[beat_cnt_r*CCU_BEAT_WIDTH +: CCU_BEAT_WIDTH];

    assign o_done = (state_r == WB_FINISH);

endmodule

`default_nettype wire

//--- src/victim_queue.sv
`timescale 1ns/10ps
`default_nettype none

module victim_queue
    import ccu_cfg_pkg::*;
    import ccu_types_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       i_arst_n,

    // Allocation from the cache on a dirty eviction
    input  wire logic       i_alloc_en,
    input  wire vq_line_t   i_alloc_line,

    // Load unit lookup
    input  wire line_addr_t i_lookup_addr,
    output logic            o_lookup_hit,

    // Drain side towards the write-back engine
    input  wire logic       i_done,
    output logic            o_head_valid,
    output vq_line_t        o_head_line,

    output logic            o_vq_full,
    output logic            o_vq_empty
);

    logic [CCU_VQ_IDX_WIDTH-1:0] alloc_ptr_r;
    logic [CCU_VQ_IDX_WIDTH-1:0] drain_ptr_r;

    logic [CCU_VQ_DEPTH-1:0] entry_alloc;
    logic [CCU_VQ_DEPTH-1:0] entry_done;
    logic [CCU_VQ_DEPTH-1:0] entry_valid;
    logic [CCU_VQ_DEPTH-1:0] entry_hit;
    vq_line_t                entry_line [CCU_VQ_DEPTH];

    // Allocate at the tail, drain from the head, both wrap
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            alloc_ptr_r <= '0;
        end else if (i_alloc_en) begin
            alloc_ptr_r <= alloc_ptr_r + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            drain_ptr_r <= '0;
        end else if (i_done) begin
            drain_ptr_r <= drain_ptr_r + 1'b1;
        end
    end

    for (genvar i = 0; i < CCU_VQ_DEPTH; i++) begin : g_entry
        // Pointer decode into per-slot strobes
        assign entry_alloc[i] = i_alloc_en && (alloc_ptr_r == CCU_VQ_IDX_WIDTH'(i));
        assign entry_done[i]  = i_done && (drain_ptr_r == CCU_VQ_IDX_WIDTH'(i));

        vq_entry u_entry (
            .clk           (clk),
            .i_arst_n      (i_arst_n),
            .i_alloc_en    (entry_alloc[i]),
            .i_alloc_line  (i_alloc_line),
            .i_lookup_addr (i_lookup_addr),
            .i_done        (entry_done[i]),
            .o_valid       (entry_valid[i]),
            .o_line        (entry_line[i]),
            .o_lookup_hit  (entry_hit[i])
        );
    end

    // Any valid slot holding the address stalls the load
    assign o_lookup_hit = |entry_hit;

    // Entries fill and drain in order, so the valid bits give the occupancy
    assign o_vq_full  = &entry_valid;
    assign o_vq_empty = ~|entry_valid;

    // Oldest victim
    assign o_head_valid = entry_valid[drain_ptr_r];
    assign o_head_line  = entry_line[drain_ptr_r];

endmodule

`default_nettype wire

//--- src/vq_entry.sv
`timescale 1ns/10ps
`default_nettype none

module vq_entry
    import ccu_types_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       i_arst_n,

    // Allocation into this slot
    input  wire logic       i_alloc_en,
    input  wire vq_line_t   i_alloc_line,

    // Load unit address match
    input  wire line_addr_t i_lookup_addr,

    // Write-back engine finished with this slot
    input  wire logic       i_done,

    output logic            o_valid,
    output vq_line_t        o_line,
    output logic            o_lookup_hit
);

    typedef enum logic {
        ENTRY_INVALID = 1'b0,
        ENTRY_VALID   = 1'b1
    } entry_state_t;

    entry_state_t state_r;
    entry_state_t state_next;
    vq_line_t     line_r;

    always_comb begin
        state_next = state_r;
        case (state_r)
            ENTRY_INVALID: state_next = i_alloc_en ? ENTRY_VALID : ENTRY_INVALID;
            ENTRY_VALID:   state_next = i_done ? ENTRY_INVALID : ENTRY_VALID;
            default:       state_next = ENTRY_INVALID;
        endcase
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state_r <= ENTRY_INVALID;
        end else begin
            state_r <= state_next;
        end
    end

    // Address and data captured on allocation
    always_ff @(posedge clk) begin
        if (i_alloc_en) begin
            line_r <= i_alloc_line;
        end
    end

    assign o_valid      = (state_r == ENTRY_VALID);
    assign o_line       = line_r;
    // Stale addresses in an empty slot must never match
    assign o_lookup_hit = o_valid && (line_r.addr == i_lookup_addr);

endmodule

`default_nettype wire

//--- tb/ccu_asserts.sv
`timescale 1ns/10ps
`default_nettype none

module ccu_asserts
    import ccu_types_pkg::*;
(
    input wire logic    clk,
    input wire logic    i_arst_n,
    input wire logic    i_alloc_en,
    input wire logic    i_vq_full,
    input wire logic    i_vq_empty,
    input wire logic    i_done,
    input wire logic    i_mem_wr_valid,
    input wire mem_wr_t i_mem_wr,
    input wire logic    i_mem_ack
);

    // A full queue has no free slot, the oldest victim would be lost
    a_no_alloc_when_full: assert property (
        @(posedge clk) disable iff (!i_arst_n) !(i_alloc_en && i_vq_full)
    ) else $error("allocation while the victim queue is full");

    a_beat_stable: assert property (
        @(posedge clk) disable iff (!i_arst_n)
        i_mem_wr_valid && !i_mem_ack |=> i_mem_wr_valid && $stable(i_mem_wr)
    ) else $error("memory beat changed before its ack");

    a_done_pulse: assert property (
        @(posedge clk) disable iff (!i_arst_n) i_done |=> !i_done
    ) else $error("done held for more than one cycle");

    a_full_empty: assert property (
        @(posedge clk) disable iff (!i_arst_n) !(i_vq_full && i_vq_empty)
    ) else $error("victim queue flagged full and empty at once");

endmodule

// Queue side
bind victim_queue ccu_asserts u_vq_asserts (
    .clk            (clk),
    .i_arst_n       (i_arst_n),
    .i_alloc_en     (i_alloc_en),
    .i_vq_full      (o_vq_full),
    .i_vq_empty     (o_vq_empty),
    .i_done         (i_done),
    .i_mem_wr_valid (1'b0),
    .i_mem_wr       ('0),
    .i_mem_ack      (1'b0)
);

// Memory side
bind ccu_writeback ccu_asserts u_wb_asserts (
    .clk            (clk),
    .i_arst_n       (i_arst_n),
    .i_alloc_en     (1'b0),
    .i_vq_full      (1'b0),
    .i_vq_empty     (1'b0),
    .i_done         (o_done),
    .i_mem_wr_valid (o_mem_wr_valid),
    .i_mem_wr       (o_mem_wr),
    .i_mem_ack      (i_mem_ack)
);

`default_nettype wire

//--- tb/tb_ccu.sv
`timescale 1ns/10ps
`default_nettype none

module tb_ccu
    import ccu_cfg_pkg::*;
    import ccu_types_pkg::*;
();

    localparam int CLK_HALF   = 20;
    localparam int WAIT_LIMIT = 2000;
    localparam int RAND_LINES = 20;

    logic       clk = 1'b0;
    logic       i_arst_n;
    logic       i_alloc_en;
    vq_line_t   i_alloc_line;
    line_addr_t i_lookup_addr;
    logic       o_lookup_hit;
    logic       o_vq_full;
    logic       o_vq_empty;
    logic       i_mem_ack = 1'b0;
    logic       o_mem_wr_valid;
    mem_wr_t    o_mem_wr;

    logic [31:0] lcg_state;
    int          err_cnt;
    int          beat_cnt;
    logic        timed_out;
    logic        ack_stall;
    logic        ack_random;
    int          ack_fixed;
    int          ack_wait = 0;
    int          rand_delay = 0;
    // Expected memory beats in write-back order
    mem_wr_t     exp_q[$];

    ccu_top dut0 (
        .clk            (clk),
        .i_arst_n       (i_arst_n),
        .i_alloc_en     (i_alloc_en),
        .i_alloc_line   (i_alloc_line),
        .i_lookup_addr  (i_lookup_addr),
        .o_lookup_hit   (o_lookup_hit),
        .o_vq_full      (o_vq_full),
        .o_vq_empty     (o_vq_empty),
        .i_mem_ack      (i_mem_ack),
        .o_mem_wr_valid (o_mem_wr_valid),
        .o_mem_wr       (o_mem_wr)
    );

    always #(CLK_HALF) clk = ~clk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp_val);
        if (got !== exp_val) begin
            err_cnt++;
            $display("mismatch %s: got %h expected %h", name, got, exp_val);
        end
    endtask

    task automatic finish_run();
        $display("errors %0d, beats %0d, beats pending %0d", err_cnt, beat_cnt, exp_q.size());
        if (err_cnt == 0 && exp_q.size() == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    endtask

    // Later waits return at once so the run reaches its end quickly
    task automatic report_timeout(input string what);
        err_cnt++;
        timed_out = 1'b1;
        $display("timeout while waiting for %s", what);
    endtask

    function automatic vq_line_t random_line();
        vq_line_t line;
        line.addr = line_addr_t'(lcg_next());
        for (int w = 0; w < CCU_LINE_WIDTH / 32; w++) begin
            line.data[w*32 +: 32] = lcg_next();
        end
        return line;
    endfunction

    // Beat k carries the k-th lowest word at byte address line base plus k words
    task automatic expect_line(input vq_line_t line);
        mem_wr_t beat;
        for (int k = 0; k < CCU_BEATS; k++) begin
            beat.addr = (32'(line.addr) << CCU_OFFSET_WIDTH) + 32'(k * (CCU_BEAT_WIDTH / 8));
            beat.data = CCU_BEAT_WIDTH'(line.data >> (k * CCU_BEAT_WIDTH));
            exp_q.push_back(beat);
        end
    endtask

    // Called on a falling edge and returns on the next one
    task automatic alloc_line(input vq_line_t line);
        i_alloc_en   = 1'b1;
        i_alloc_line = line;
        expect_line(line);
        @(negedge clk);
        i_alloc_en = 1'b0;
    endtask

    task automatic check_lookup(input line_addr_t addr, input logic exp_hit);
        i_lookup_addr = addr;
        #(CLK_HALF / 2);
        check_value("o_lookup_hit", 64'(o_lookup_hit), 64'(exp_hit));
        @(negedge clk);
    endtask

    task automatic wait_not_full();
        int n;
        n = 0;
        while (o_vq_full && !timed_out) begin
            @(negedge clk);
            n++;
            if (n >= WAIT_LIMIT) report_timeout("the victim queue to leave full");
        end
    endtask

    // Returns in the cycle where the last entry has just been freed
    task automatic wait_drained(input string what);
        int n;
        n = 0;
        while (!timed_out && (exp_q.size() != 0 || o_mem_wr_valid)) begin
            @(negedge clk);
            n++;
            if (n >= WAIT_LIMIT) report_timeout(what);
        end
        // Done is high now, the entry frees on the next edge
        @(negedge clk);
    endtask

    task automatic take_beat();
        mem_wr_t exp_beat;
        if (exp_q.size() == 0) begin
            err_cnt++;
            $display("memory beat arrived with no victim line left to write back");
        end else begin
            exp_beat = exp_q.pop_front();
            check_value("o_mem_wr.addr", 64'(o_mem_wr.addr), 64'(exp_beat.addr));
            check_value("o_mem_wr.data", o_mem_wr.data, exp_beat.data);
        end
        beat_cnt++;
    endtask

    // Memory responder, one ack per beat after a fixed or random wait
    always @(negedge clk) begin
        if (!i_arst_n || i_mem_ack) begin
            i_mem_ack = 1'b0;
            ack_wait  = 0;
        end else if (o_mem_wr_valid && !ack_stall) begin
            if (ack_wait >= (ack_random ? rand_delay : ack_fixed)) begin
                take_beat();
                i_mem_ack  = 1'b1;
                rand_delay = int'(lcg_next() % 32'd4);
            end else begin
                ack_wait++;
            end
        end
    end

    task automatic test_reset_state();
        check_value("o_vq_empty", 64'(o_vq_empty), 64'd1);
        check_value("o_vq_full", 64'(o_vq_full), 64'd0);
        check_value("o_mem_wr_valid", 64'(o_mem_wr_valid), 64'd0);
        check_lookup(line_addr_t'(lcg_next()), 1'b0);
    endtask

    task automatic test_single_victim();
        ack_fixed = 1;
        alloc_line(random_line());
        wait_drained("a single victim to drain");
        check_value("o_vq_empty", 64'(o_vq_empty), 64'd1);
        // The engine stays idle once the only line is written back
        @(negedge clk);
        check_value("o_mem_wr_valid", 64'(o_mem_wr_valid), 64'd0);
    endtask

    task automatic test_lookup_lifetime();
        vq_line_t line;
        line      = random_line();
        ack_stall = 1'b1;
        alloc_line(line);
        check_lookup(line.addr, 1'b1);
        check_lookup(line.addr ^ line_addr_t'(1), 1'b0);
        ack_stall = 1'b0;
        wait_drained("the looked-up line to drain");
        check_lookup(line.addr, 1'b0);
    endtask

    // Scoreboard order checks that lines leave in allocation order
    task automatic test_fill_order();
        ack_stall = 1'b1;
        for (int n = 0; n < CCU_VQ_DEPTH; n++) begin
            alloc_line(random_line());
        end
        check_value("o_vq_full", 64'(o_vq_full), 64'd1);
        ack_stall = 1'b0;
        wait_drained("the full queue to drain");
    endtask

    task automatic test_random_backpressure();
        ack_random = 1'b1;
        for (int n = 0; n < RAND_LINES; n++) begin
            wait_not_full();
            alloc_line(random_line());
        end
        wait_drained("random traffic to drain");
        check_value("o_vq_empty", 64'(o_vq_empty), 64'd1);
        ack_random = 1'b0;
    endtask

    initial begin
        lcg_state     = 32'h62348f03;
        err_cnt       = 0;
        beat_cnt      = 0;
        timed_out     = 1'b0;
        ack_stall     = 1'b0;
        ack_random    = 1'b0;
        ack_fixed     = 0;
        i_arst_n      = 1'b0;
        i_alloc_en    = 1'b0;
        i_alloc_line  = '0;
        i_lookup_addr = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        i_arst_n = 1'b1;
        @(negedge clk);
        test_reset_state();
        test_single_victim();
        test_lookup_lifetime();
        test_fill_order();
        test_random_backpressure();
        finish_run();
    end

endmodule

`default_nettype wire
